/* design/riscvIsaPkg.sv */
package riscvIsaPkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcodeT;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3T;

    // branch conditions share encodings with the arithmetic group
    localparam funct3T F3_BEQ = F3_ADD_SUB;
    localparam funct3T F3_BNE = F3_SLL;

    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000
    } funct7T;

    typedef enum logic [2:0] {
        IT_R,
        IT_I,
        IT_S,
        IT_SB,
        IT_U,
        IT_UJ,
        IT_UNDEF
    } instrTypeT;

endpackage

/* design/coreCtrlPkg.sv */
package coreCtrlPkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } aluOpT;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'd0,
        PC_TARGET = 2'd1,
        PC_JALR   = 2'd2
    } pcSelT;

    typedef enum logic [1:0] {
        OP1_RS1  = 2'd0,
        OP1_ZERO = 2'd1
    } op1SelT;

    typedef enum logic [2:0] {
        OP2_RS2   = 3'd0,
        OP2_IMM_I = 3'd1,
        OP2_SHAMT = 3'd2,
        OP2_IMM_S = 3'd3,
        OP2_IMM_B = 3'd4,
        OP2_IMM_U = 3'd5,
        OP2_IMM_J = 3'd6
    } op2SelT;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wbSelT;

endpackage

/* design/coreControl.sv */
`timescale 1ns/100ps

module coreControl
    import riscvIsaPkg::*;
    import coreCtrlPkg::*;
(
    input  logic [31:0] instruction,
    output pcSelT       pcSel,
    output op1SelT      op1Sel,
    output op2SelT      op2Sel,
    output aluOpT       aluOp,
    output wbSelT       wbSel,
    output logic        linkSel,
    output logic        regWriteEn,
    output logic        memReadEn,
    output logic        memWriteEn,
    output logic        isBeq,
    output logic        isBne
);

    opcodeT    opcode;
    funct3T    funct3;
    funct7T    funct7;
    instrTypeT instrType;
    logic      funct7Ok;

    assign opcode = opcodeT'(instruction[6:0]);
    assign funct3 = funct3T'(instruction[14:12]);
    assign funct7 = funct7T'(instruction[31:25]);

    always_comb begin
        case (opcode)
            OPC_LUI:    instrType = IT_U;
            OPC_JAL:    instrType = IT_UJ;
            OPC_JALR,
            OPC_LOAD,
            OPC_OPIMM:  instrType = IT_I;
            OPC_BRANCH: instrType = IT_SB;
            OPC_STORE:  instrType = IT_S;
            OPC_OP:     instrType = IT_R;
            default:    instrType = IT_UNDEF;
        endcase
    end

    // for addi and friends funct7 is immediate bits, only shifts care
    always_comb begin
        case (funct3)
            F3_ADD_SUB: funct7Ok = (opcode == OPC_OPIMM) || funct7 == F7_BASE || funct7 == F7_ALT;
            F3_SRL_SRA: funct7Ok = funct7 == F7_BASE || funct7 == F7_ALT;
            F3_SLL:     funct7Ok = funct7 == F7_BASE;
            default:    funct7Ok = (opcode == OPC_OPIMM) || funct7 == F7_BASE;
        endcase
    end

    always_comb begin
        aluOp = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OPIMM) begin
            case (funct3)
                F3_ADD_SUB: aluOp = (opcode == OPC_OP && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                F3_SLL:     aluOp = ALU_SLL;
                F3_SLT:     aluOp = ALU_SLT;
                F3_SLTU:    aluOp = ALU_SLTU;
                F3_XOR:     aluOp = ALU_XOR;
                F3_SRL_SRA: aluOp = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                F3_OR:      aluOp = ALU_OR;
                F3_AND:     aluOp = ALU_AND;
                default:    aluOp = ALU_ADD;
            endcase
            // bad funct7 falls back to a harmless add
            if (!funct7Ok) begin
                aluOp = ALU_ADD;
            end
        end
    end

    always_comb begin
        pcSel      = PC_PLUS4;
        op1Sel     = OP1_RS1;
        op2Sel     = OP2_RS2;
        wbSel      = WB_ALU;
        linkSel    = 1'b0;
        regWriteEn = 1'b0;
        memReadEn  = 1'b0;
        memWriteEn = 1'b0;
        isBeq      = 1'b0;
        isBne      = 1'b0;
        case (instrType)
            IT_R: begin
                regWriteEn = funct7Ok;
            end
            IT_I: begin
                op2Sel     = OP2_IMM_I;
                regWriteEn = 1'b1;
                case (opcode)
                    OPC_LOAD: begin
                        memReadEn = 1'b1;
                        wbSel     = WB_MEM;
                    end
                    OPC_JALR: begin
                        pcSel   = PC_JALR;
                        linkSel = 1'b1;
                    end
                    default: begin
                        if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
                            op2Sel = OP2_SHAMT;
                        end
                        regWriteEn = funct7Ok;
                    end
                endcase
            end
            IT_S: begin
                op2Sel     = OP2_IMM_S;
                memWriteEn = 1'b1;
            end
            IT_SB: begin
                // only beq and bne are taken, other conditions fall through
                op2Sel = OP2_IMM_B;
                isBeq  = funct3 == F3_BEQ;
                isBne  = funct3 == F3_BNE;
                if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
                    pcSel = PC_TARGET;
                end
            end
            IT_U: begin
                op1Sel     = OP1_ZERO;
                op2Sel     = OP2_IMM_U;
                regWriteEn = 1'b1;
            end
            IT_UJ: begin
                op1Sel     = OP1_ZERO;
                op2Sel     = OP2_IMM_J;
                pcSel      = PC_TARGET;
                linkSel    = 1'b1;
                regWriteEn = 1'b1;
            end
            default: begin
                // undefined opcode runs as a nop
                pcSel = PC_PLUS4;
            end
        endcase
    end

    always_comb begin
        assert (!(memReadEn && memWriteEn))
            else $error("coreControl: load and store decoded together");
    end

endmodule

/* design/operandMux.sv */
`timescale 1ns/100ps

module operandMux
    import coreCtrlPkg::*;
(
    input  logic [31:0] instruction,
    input  op1SelT      op1Sel,
    input  op2SelT      op2Sel,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data,
    output logic [31:0] aluA,
    output logic [31:0] aluB
);

    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    logic [31:0] shamt;

    assign immI  = {{20{instruction[31]}}, instruction[31:20]};
    assign immS  = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB  = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign immU  = {instruction[31:12], 12'b0};
    assign immJ  = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};
    // shift amount is zero extended
    assign shamt = {27'b0, instruction[24:20]};

    assign aluA = (op1Sel == OP1_ZERO) ? 32'b0 : rs1Data;

    always_comb begin
        case (op2Sel)
            OP2_IMM_I: aluB = immI;
            OP2_SHAMT: aluB = shamt;
            OP2_IMM_S: aluB = immS;
            OP2_IMM_B: aluB = immB;
            OP2_IMM_U: aluB = immU;
            OP2_IMM_J: aluB = immJ;
            default:   aluB = rs2Data;
        endcase
    end

endmodule

/* design/alu.sv */
`timescale 1ns/100ps

module alu
    import coreCtrlPkg::*;
(
    input  aluOpT       aluOp,
    input  logic [31:0] aluA,
    input  logic [31:0] aluB,
    output logic [31:0] aluResult
);

    logic [4:0] shiftAmt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shiftAmt     = aluB[4:0];
    assign lessSigned   = $signed(aluA) < $signed(aluB);
    assign lessUnsigned = aluA < aluB;

    always_comb begin
        case (aluOp)
            ALU_ADD:  aluResult = aluA + aluB;
            ALU_SUB:  aluResult = aluA - aluB;
            ALU_SLL:  aluResult = aluA << shiftAmt;
            ALU_SLT:  aluResult = {31'b0, lessSigned};
            ALU_SLTU: aluResult = {31'b0, lessUnsigned};
            ALU_XOR:  aluResult = aluA ^ aluB;
            ALU_SRL:  aluResult = aluA >> shiftAmt;
            ALU_SRA:  aluResult = $unsigned($signed(aluA) >>> shiftAmt);
            ALU_OR:   aluResult = aluA | aluB;
            ALU_AND:  aluResult = aluA & aluB;
            default:  aluResult = aluA + aluB;
        endcase
    end

endmodule

/* design/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic        writeEn,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // same-cycle write is forwarded, x0 always reads zero
    assign rs1Data = (writeEn && writeAddr == rs1Addr && rs1Addr != 5'd0) ? writeData
                                                                          : regs[rs1Addr];
    assign rs2Data = (writeEn && writeAddr == rs2Addr && rs2Addr != 5'd0) ? writeData
                                                                          : regs[rs2Addr];

    // writeback stage must filter rd == 0 before it gets here
    assert property (@(posedge clk) disable iff (!rstN) writeEn |-> writeAddr != 5'd0)
        else $error("regFile: write strobe aimed at x0");

endmodule

/* design/dataMem.sv */
`timescale 1ns/100ps

module dataMem #(
    parameter int memWords = 256
) (
    input  logic        clk,
    input  logic        readEn,
    input  logic        writeEn,
    input  logic [31:0] addr,
    input  logic [31:0] writeData,
    output logic [31:0] readData
);

    localparam int idxBits = $clog2(memWords);

    logic [31:0]        mem [memWords];
    logic [idxBits-1:0] wordIdx;

    assign wordIdx = addr[idxBits+1:2];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[wordIdx] <= writeData;
        end
        if (readEn) begin
            readData <= mem[wordIdx];
        end
    end

    assert property (@(posedge clk) (readEn || writeEn) |-> addr[1:0] == 2'b00)
        else $error("dataMem: misaligned word access at %h", addr);

endmodule

/* design/pcUnit.sv */
`timescale 1ns/100ps

module pcUnit
    import coreCtrlPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        advance,
    input  pcSelT       pcSel,
    input  logic        isBeq,
    input  logic        isBne,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data,
    input  logic [31:0] target,
    input  logic [31:0] jalrTarget,
    output logic [31:0] pc,
    output logic [31:0] pcPlus4
);

    logic        isBranch;
    logic        branchTaken;
    logic [31:0] nextPc;

    assign pcPlus4     = pc + 32'd4;
    assign isBranch    = isBeq || isBne;
    assign branchTaken = (isBeq && rs1Data == rs2Data) || (isBne && rs1Data != rs2Data);

    always_comb begin
        case (pcSel)
            // jal always jumps, a branch only when its condition holds
            PC_TARGET: nextPc = (isBranch && !branchTaken) ? pcPlus4 : target;
            PC_JALR:   nextPc = {jalrTarget[31:1], 1'b0};
            default:   nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (advance) begin
            pc <= nextPc;
        end
    end

endmodule

/* design/riscvCore.sv */
`timescale 1ns/100ps

module riscvCore
    import coreCtrlPkg::*;
#(
    parameter int memWords = 256
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        instrValid,
    input  logic [31:0] instruction,
    output logic [31:0] pc,
    output logic        wbValid,
    output logic [4:0]  wbRd,
    output logic [31:0] wbData,
    output logic        memWriteEn,
    output logic [31:0] memAddr,
    output logic [31:0] memWriteData
);

    pcSelT       pcSel;
    op1SelT      op1Sel;
    op2SelT      op2Sel;
    aluOpT       aluOp;
    wbSelT       wbSel;
    logic        linkSel;
    logic        regWriteEn;
    logic        memReadEn;
    logic        ctrlMemWriteEn;
    logic        isBeq;
    logic        isBne;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] pcPlus4;
    logic [31:0] target;
    logic [31:0] memReadData;

    // stage two register
    logic        stValid;
    logic        stRegWriteEn;
    wbSelT       stWbSel;
    logic [4:0]  stRd;
    logic [31:0] stResult;

    coreControl u_control (
        .instruction (instruction),
        .pcSel       (pcSel),
        .op1Sel      (op1Sel),
        .op2Sel      (op2Sel),
        .aluOp       (aluOp),
        .wbSel       (wbSel),
        .linkSel     (linkSel),
        .regWriteEn  (regWriteEn),
        .memReadEn   (memReadEn),
        .memWriteEn  (ctrlMemWriteEn),
        .isBeq       (isBeq),
        .isBne       (isBne)
    );

    regFile u_regFile (
        .clk       (clk),
        .rstN      (rstN),
        .rs1Addr   (instruction[19:15]),
        .rs2Addr   (instruction[24:20]),
        .writeEn   (wbValid),
        .writeAddr (wbRd),
        .writeData (wbData),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    operandMux u_operandMux (
        .instruction (instruction),
        .op1Sel      (op1Sel),
        .op2Sel      (op2Sel),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .aluA        (aluA),
        .aluB        (aluB)
    );

    alu u_alu (
        .aluOp     (aluOp),
        .aluA      (aluA),
        .aluB      (aluB),
        .aluResult (aluResult)
    );

    // for branches and jal operand B carries the offset
    assign target = pc + aluB;

    pcUnit u_pcUnit (
        .clk        (clk),
        .rstN       (rstN),
        .advance    (instrValid),
        .pcSel      (pcSel),
        .isBeq      (isBeq),
        .isBne      (isBne),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .target     (target),
        .jalrTarget (aluResult),
        .pc         (pc),
        .pcPlus4    (pcPlus4)
    );

    assign memWriteEn   = ctrlMemWriteEn && instrValid;
    assign memAddr      = aluResult;
    assign memWriteData = rs2Data;

    dataMem #(
        .memWords (memWords)
    ) u_dataMem (
        .clk       (clk),
        .readEn    (memReadEn && instrValid),
        .writeEn   (memWriteEn),
        .addr      (memAddr),
        .writeData (memWriteData),
        .readData  (memReadData)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stValid      <= 1'b0;
            stRegWriteEn <= 1'b0;
            stWbSel      <= WB_ALU;
        end else begin
            stValid      <= instrValid;
            stRegWriteEn <= regWriteEn;
            stWbSel      <= wbSel;
        end
    end

    always_ff @(posedge clk) begin
        stRd     <= instruction[11:7];
        stResult <= linkSel ? pcPlus4 : aluResult;
    end

    // load data arrives from the memory in this cycle
    assign wbValid = stValid && stRegWriteEn && stRd != 5'd0;
    assign wbRd    = stRd;
    assign wbData  = (stWbSel == WB_MEM) ? memReadData : stResult;

endmodule

/* bench/clockGen.sv */
`timescale 1ns/100ps

module clockGen #(
    parameter int halfPeriod  = 4,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // release just after an edge, like the rest of the stimulus
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

/* bench/coreTb.sv */
`timescale 1ns/100ps

module coreTb
    import riscvIsaPkg::*;
();

    localparam int timeoutCycles = 2000;
    localparam logic [31:0] nopWord = 32'h0000_0013;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instruction;
    logic [31:0] pc;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        memWriteEn;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;

    int          seed = 32'h4bc72f55;
    int          errorCount = 0;
    int          timeoutCount = 0;
    logic [31:0] prog [64];
    int          progLen;
    logic [31:0] progEnd;
    logic [31:0] haltPc;

    // reference machine state
    logic [31:0] refRegs [32];
    logic [31:0] refMem [256];
    logic [31:0] refPc;
    logic        pendWbValid;
    logic [4:0]  pendWbRd;
    logic [31:0] pendWbData;

    // what the DUT must show before the next edge
    logic [31:0] expPc;
    logic        expWbValid;
    logic [4:0]  expWbRd;
    logic [31:0] expWbData;
    logic        expStoreEn;
    logic [31:0] expStoreAddr;
    logic [31:0] expStoreData;

    clockGen #(
        .halfPeriod  (4),
        .resetCycles (5)
    ) u_clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    riscvCore #(
        .memWords (256)
    ) u_dut (
        .clk          (clk),
        .rstN         (rstN),
        .instrValid   (instrValid),
        .instruction  (instruction),
        .pc           (pc),
        .wbValid      (wbValid),
        .wbRd         (wbRd),
        .wbData       (wbData),
        .memWriteEn   (memWriteEn),
        .memAddr      (memAddr),
        .memWriteData (memWriteData)
    );

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, opcodeT opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] encU(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic isReg,
                                           logic [31:0] a, logic [31:0] b);
        case (f3)
            3'b000:  return (isReg && alt) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        progLen = 0;
        // dependent chain straight after reset
        emit(encI(12'($random(seed)), 5'd0, F3_ADD_SUB, 5'd1, OPC_OPIMM));
        emit(encI(12'($random(seed)), 5'd1, F3_ADD_SUB, 5'd2, OPC_OPIMM));
        emit(encR(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd3));
        emit(encR(F7_ALT, 5'd1, 5'd3, F3_ADD_SUB, 5'd4));
        emit(encR(F7_BASE, 5'd2, 5'd3, F3_SLL, 5'd5));
        emit(encR(F7_BASE, 5'd4, 5'd1, F3_SLT, 5'd6));
        emit(encR(F7_BASE, 5'd4, 5'd1, F3_SLTU, 5'd7));
        emit(encR(F7_BASE, 5'd2, 5'd4, F3_XOR, 5'd8));
        emit(encR(F7_BASE, 5'd1, 5'd4, F3_SRL_SRA, 5'd9));
        emit(encR(F7_ALT, 5'd1, 5'd4, F3_SRL_SRA, 5'd10));
        emit(encR(F7_BASE, 5'd8, 5'd3, F3_OR, 5'd11));
        emit(encR(F7_BASE, 5'd8, 5'd3, F3_AND, 5'd12));
        emit(encI(12'($random(seed)), 5'd4, F3_SLT, 5'd13, OPC_OPIMM));
        emit(encI(12'($random(seed)), 5'd4, F3_SLTU, 5'd14, OPC_OPIMM));
        emit(encI(12'($random(seed)), 5'd8, F3_XOR, 5'd15, OPC_OPIMM));
        emit(encI(12'($random(seed)), 5'd8, F3_OR, 5'd16, OPC_OPIMM));
        emit(encI(12'($random(seed)), 5'd8, F3_AND, 5'd17, OPC_OPIMM));
        emit(encI({F7_BASE, 5'($random(seed))}, 5'd3, F3_SLL, 5'd18, OPC_OPIMM));
        emit(encI({F7_BASE, 5'($random(seed))}, 5'd4, F3_SRL_SRA, 5'd19, OPC_OPIMM));
        emit(encI({F7_ALT, 5'($random(seed))}, 5'd4, F3_SRL_SRA, 5'd20, OPC_OPIMM));
        emit(encU(20'($random(seed)), 5'd21));
        // store then load back, load result used at once
        emit(encI(12'h040, 5'd0, F3_ADD_SUB, 5'd22, OPC_OPIMM));
        emit(encS(12'd8, 5'd21, 5'd22));
        emit(encS(12'd12, 5'd20, 5'd22));
        emit(encI(12'd8, 5'd22, 3'b010, 5'd23, OPC_LOAD));
        emit(encI(12'd12, 5'd22, 3'b010, 5'd24, OPC_LOAD));
        emit(encR(F7_BASE, 5'd24, 5'd23, F3_ADD_SUB, 5'd25));
        // no writeback expected from these two
        emit(encI(12'h005, 5'd1, F3_ADD_SUB, 5'd0, OPC_OPIMM));
        emit(32'hFFFF_FFFF);
        emit(encB(13'd8, 5'd21, 5'd23, 3'b000));
        emit(encI(12'd1, 5'd0, F3_ADD_SUB, 5'd26, OPC_OPIMM));
        emit(encB(13'd8, 5'd21, 5'd23, 3'b001));
        emit(encB(13'd8, 5'd2, 5'd1, 3'b001));
        emit(encI(12'd2, 5'd0, F3_ADD_SUB, 5'd26, OPC_OPIMM));
        emit(encB(13'd8, 5'd2, 5'd1, 3'b000));
        emit(encJ(21'd8, 5'd27));
        emit(encI(12'd3, 5'd0, F3_ADD_SUB, 5'd26, OPC_OPIMM));
        // odd jalr sum checks that bit zero is cleared
        emit(encI(12'((progLen + 3) * 4), 5'd0, F3_ADD_SUB, 5'd28, OPC_OPIMM));
        emit(encI(12'd1, 5'd28, F3_ADD_SUB, 5'd29, OPC_JALR));
        emit(encI(12'd4, 5'd0, F3_ADD_SUB, 5'd26, OPC_OPIMM));
        emit(encR(F7_BASE, 5'd29, 5'd27, F3_ADD_SUB, 5'd30));
        emit(encS(12'd16, 5'd30, 5'd22));
        emit(encI(12'd16, 5'd22, 3'b010, 5'd31, OPC_LOAD));
        emit(encJ(21'd0, 5'd0));
        haltPc  = 32'((progLen - 1) * 4);
        progEnd = 32'(progLen * 4);
    endtask

    task automatic executeRef(input logic [31:0] word);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immJ;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic        doWrite;
        opc     = word[6:0];
        f3      = word[14:12];
        rd      = word[11:7];
        a       = refRegs[word[19:15]];
        b       = refRegs[word[24:20]];
        immI    = {{20{word[31]}}, word[31:20]};
        immS    = {{20{word[31]}}, word[31:25], word[11:7]};
        immB    = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        immJ    = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        res     = 32'd0;
        doWrite = 1'b0;
        nextPc  = refPc + 32'd4;
        case (opc)
            OPC_LUI: begin
                res     = {word[31:12], 12'd0};
                doWrite = 1'b1;
            end
            OPC_JAL: begin
                res     = refPc + 32'd4;
                doWrite = 1'b1;
                nextPc  = refPc + immJ;
            end
            OPC_JALR: begin
                res     = refPc + 32'd4;
                doWrite = 1'b1;
                nextPc  = (a + immI) & ~32'd1;
            end
            OPC_LOAD: begin
                addr    = a + immI;
                res     = refMem[addr[9:2]];
                doWrite = 1'b1;
            end
            OPC_STORE: begin
                addr               = a + immS;
                refMem[addr[9:2]]  = b;
                expStoreEn         = 1'b1;
                expStoreAddr       = addr;
                expStoreData       = b;
            end
            OPC_BRANCH: begin
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                    nextPc = refPc + immB;
                end
            end
            OPC_OPIMM: begin
                res     = aluRef(f3, word[30], 1'b0, a, immI);
                doWrite = 1'b1;
            end
            OPC_OP: begin
                res     = aluRef(f3, word[30], 1'b1, a, b);
                doWrite = 1'b1;
            end
            default: begin
                doWrite = 1'b0;
            end
        endcase
        if (doWrite && rd != 5'd0) begin
            refRegs[rd] = res;
            pendWbValid = 1'b1;
            pendWbRd    = rd;
            pendWbData  = res;
        end
        refPc = nextPc;
    endtask

    // one cycle of fetch, just after the rising edge
    task automatic stepCycle();
        logic [31:0] word;
        expWbValid  = pendWbValid;
        expWbRd     = pendWbRd;
        expWbData   = pendWbData;
        pendWbValid = 1'b0;
        expStoreEn  = 1'b0;
        expPc       = refPc;
        word        = (pc < progEnd) ? prog[pc[7:2]] : nopWord;
        instrValid  = ($unsigned($random(seed)) % 6) != 0;
        instruction = word;
        if (instrValid) begin
            executeRef(word);
        end
    endtask

    task automatic endSimulation();
        $display("errors: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    assert property (@(posedge clk) disable iff (!rstN) pc == expPc)
        else begin
            errorCount = errorCount + 1;
            $display("FAILED pc: got %h expected %h", $sampled(pc), $sampled(expPc));
        end

    assert property (@(posedge clk) disable iff (!rstN) wbValid == expWbValid)
        else begin
            errorCount = errorCount + 1;
            $display("FAILED wbValid: got %h expected %h", $sampled(wbValid),
                     $sampled(expWbValid));
        end

    assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbRd == expWbRd)
        else begin
            errorCount = errorCount + 1;
            $display("FAILED wbRd: got %h expected %h", $sampled(wbRd), $sampled(expWbRd));
        end

    assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbData == expWbData)
        else begin
            errorCount = errorCount + 1;
            $display("FAILED wbData: got %h expected %h", $sampled(wbData),
                     $sampled(expWbData));
        end

    assert property (@(posedge clk) disable iff (!rstN) memWriteEn == expStoreEn)
        else begin
            errorCount = errorCount + 1;
            $display("FAILED memWriteEn: got %h expected %h", $sampled(memWriteEn),
                     $sampled(expStoreEn));
        end

    assert property (@(posedge clk) disable iff (!rstN)
                     memWriteEn |-> memAddr == expStoreAddr && memWriteData == expStoreData)
        else begin
            errorCount = errorCount + 1;
            $display("FAILED memAddr/memWriteData: got %h/%h expected %h/%h",
                     $sampled(memAddr), $sampled(memWriteData),
                     $sampled(expStoreAddr), $sampled(expStoreData));
        end

    initial begin
        int resetWait;
        int runCycles;
        int drain;
        instrValid   = 1'b0;
        instruction  = nopWord;
        refPc        = 32'd0;
        pendWbValid  = 1'b0;
        pendWbRd     = 5'd0;
        pendWbData   = 32'd0;
        expPc        = 32'd0;
        expWbValid   = 1'b0;
        expWbRd      = 5'd0;
        expWbData    = 32'd0;
        expStoreEn   = 1'b0;
        expStoreAddr = 32'd0;
        expStoreData = 32'd0;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = 32'd0;
        end
        buildProgram();

        resetWait = 0;
        while (rstN !== 1'b1 && resetWait < timeoutCycles) begin
            @(posedge clk);
            resetWait++;
        end
        if (rstN !== 1'b1) begin
            $display("reset was never released");
            timeoutCount++;
        end

        // a few extra cycles on the halt loop let the last writeback show
        runCycles = 0;
        drain     = 0;
        while (timeoutCount == 0 && drain < 4) begin
            @(posedge clk);
            #1;
            stepCycle();
            if (refPc == haltPc) begin
                drain++;
            end
            runCycles++;
            if (runCycles >= timeoutCycles) begin
                $display("program did not reach its halt loop within %0d cycles",
                         timeoutCycles);
                timeoutCount++;
            end
        end
        endSimulation();
    end

endmodule

/* list.f */
design/riscvIsaPkg.sv
design/coreCtrlPkg.sv
design/coreControl.sv
design/operandMux.sv
design/alu.sv
design/regFile.sv
design/dataMem.sv
design/pcUnit.sv
design/riscvCore.sv
bench/clockGen.sv
bench/coreTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module coreTb -f list.f

output=$(./obj_dir/VcoreTb)
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
